// ==== tb.f ====
source/spi_reg_pkg.sv
source/spi_slave.sv
source/spi_cmd_decoder.sv
source/reg_bank.sv
source/spi_reg_top.sv
tb/tb_clk_gen.sv
tb/spi_reg_assertions.sv
tb/tb_spi_reg.sv

// ==== Makefile ====
# Verilator build and run for the SPI register bank testbench
# The run target exits non-zero when the testbench stops with $fatal

SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: obj_dir/Vtb_spi_reg

# Rebuild only when a source or the file list changes
obj_dir/Vtb_spi_reg: tb.f $(SRCS)
	verilator --binary --assert --top-module tb_spi_reg -f tb.f -o Vtb_spi_reg

# Error limit raised so the testbench sees assertion failures and prints its verdict
run: obj_dir/Vtb_spi_reg
	./obj_dir/Vtb_spi_reg +verilator+error+limit+100

clean:
	rm -rf obj_dir

// ==== tb/tb_spi_reg.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the SPI register bank
// Master runs in the package SPI mode, 8 i_Clk cycles per SPI clock
// Idles 10 i_Clk cycles after CS falls and between bytes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_spi_reg;

  import spi_reg_pkg::*;

  localparam int          HALF_SCK   = 4;
  localparam int          GAP_CYCLES = 10;
  localparam int          WAIT_LIMIT = 100;
  localparam int unsigned SEED       = 32'hc4f2_6180;
  // Idle level and phase of the master clock
  localparam logic CPOL = (SPI_MODE == 2) || (SPI_MODE == 3);
  localparam logic CPHA = (SPI_MODE == 1) || (SPI_MODE == 3);

  logic        clk;
  logic        rst;
  logic        spi_clk;
  logic        spi_cs_n;
  logic        spi_mosi;
  logic        spi_miso;
  logic        spi_miso_en;
  logic [7:0]  ctrl;
  logic [7:0]  model_regs [0:REG_COUNT-1];
  logic [7:0]  tx_q [$];
  logic [7:0]  rx_q [$];
  int unsigned seed_out;
  logic [3:0]  addr;
  logic [7:0]  data;

  tb_clk_gen clk_gen0
  (
    .o_clk (clk),
    .o_rst (rst)
  );

  spi_reg_top dut0
  (
    .i_Clk         (clk),
    .i_rst         (rst),
    .i_spi_clk     (spi_clk),
    .i_spi_cs_n    (spi_cs_n),
    .i_spi_mosi    (spi_mosi),
    .o_spi_miso    (spi_miso),
    .o_spi_miso_en (spi_miso_en),
    .o_ctrl        (ctrl)
  );

  bind spi_reg_top spi_reg_assertions asrt0
  (
    .i_Clk         (i_Clk),
    .i_rst         (i_rst),
    .i_spi_cs_n    (i_spi_cs_n),
    .i_spi_miso_en (o_spi_miso_en),
    .i_rx          (w_rx),
    .i_req         (w_req),
    .i_rd_data     (w_rd_data),
    .i_rd_valid    (w_rd_valid),
    .i_ctrl        (o_ctrl)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    assert (got === exp)
    else
      stop_on_error($sformatf("[ERROR] %0t: %s got %02h, expected %02h",
                              $time, what, got, exp));
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Clocks nbits bits, MSB first, and returns what came back on MISO
  task automatic spi_transfer(input int nbits, input logic [7:0] tx_byte,
                              output logic [7:0] rx_byte);
    logic [7:0] shift_out;
    logic       first;
    shift_out = tx_byte;
    rx_byte   = 8'h00;
    first     = 1'b1;
    repeat (nbits)
    begin
      if (!CPHA)
        spi_mosi = shift_out[7];
      idle_cycles(HALF_SCK);
      // Phase 1 samples after the trailing edge of the previous bit
      if (CPHA && !first)
        rx_byte = {rx_byte[6:0], spi_miso};
      spi_clk = ~CPOL;
      if (CPHA)
        spi_mosi = shift_out[7];
      shift_out = {shift_out[6:0], 1'b0};
      idle_cycles(HALF_SCK);
      if (!CPHA)
        rx_byte = {rx_byte[6:0], spi_miso};
      spi_clk = CPOL;
      first   = 1'b0;
    end
    idle_cycles(HALF_SCK);
    if (CPHA)
      rx_byte = {rx_byte[6:0], spi_miso};
  endtask

  // CS low, then wait for the slave to take the MISO pin
  task automatic select_slave();
    int cnt;
    cnt      = 0;
    spi_cs_n = 1'b0;
    idle_cycles(1);
    while (!spi_miso_en && (cnt < WAIT_LIMIT))
    begin
      idle_cycles(1);
      cnt++;
    end
    if (!spi_miso_en)
      stop_on_error("Timed out waiting for MISO enable after chip select");
    idle_cycles(GAP_CYCLES);
  endtask

  task automatic release_slave();
    spi_cs_n = 1'b1;
    idle_cycles(GAP_CYCLES);
  endtask

  // Sends every byte of tx_q in one CS window, collects rx_q
  task automatic run_transaction();
    logic [7:0] rx_byte;
    rx_q.delete();
    select_slave();
    foreach (tx_q[i])
    begin
      spi_transfer(8, tx_q[i], rx_byte);
      rx_q.push_back(rx_byte);
      idle_cycles(GAP_CYCLES);
    end
    release_slave();
  endtask

  // Command with random ignored bits 6..4
  function automatic logic [7:0] make_cmd(input logic wr, input logic [3:0] start);
    logic [7:0] cmd;
    cmd                = 8'($urandom_range(0, 255)) & 8'h70;
    cmd[CMD_WRITE_BIT] = wr;
    cmd[3:0]           = start;
    return cmd;
  endfunction

  // First data byte is given, the rest are random
  task automatic write_regs(input logic [3:0] start, input int n, input logic [7:0] first_data);
    logic [3:0] a;
    logic [7:0] d;
    tx_q.delete();
    tx_q.push_back(make_cmd(1'b1, start));
    a = start;
    d = first_data;
    repeat (n)
    begin
      tx_q.push_back(d);
      // Register 0 keeps its ID
      if (a != 4'd0)
        model_regs[a] = d;
      a = a + 4'd1;
      d = 8'($urandom_range(0, 255));
    end
    run_transaction();
    check_byte(rx_q.pop_front(), STATUS_VALUE, "status byte of write");
  endtask

  task automatic read_regs(input logic [3:0] start, input int n);
    logic [3:0] a;
    tx_q.delete();
    tx_q.push_back(make_cmd(1'b0, start));
    // MOSI content is ignored during a read
    repeat (n) tx_q.push_back(8'($urandom_range(0, 255)));
    run_transaction();
    check_byte(rx_q.pop_front(), STATUS_VALUE, "status byte of read");
    a = start;
    repeat (n)
    begin
      check_byte(rx_q.pop_front(), model_regs[a], $sformatf("read of register %0d", a));
      a = a + 4'd1;
    end
  endtask

  // Polls o_ctrl for a bounded time, then compares
  task automatic check_ctrl(input logic [7:0] exp);
    int cnt;
    cnt = 0;
    while ((ctrl !== exp) && (cnt < WAIT_LIMIT))
    begin
      idle_cycles(1);
      cnt++;
    end
    check_byte(ctrl, exp, "o_ctrl");
  endtask

  // Raises CS after a partial byte, optionally behind a full command
  task automatic abort_mid_byte(input logic send_cmd, input logic [7:0] cmd, input int nbits);
    logic [7:0] rx_byte;
    select_slave();
    if (send_cmd)
    begin
      spi_transfer(8, cmd, rx_byte);
      idle_cycles(GAP_CYCLES);
    end
    spi_transfer(nbits, 8'($urandom_range(0, 255)), rx_byte);
    release_slave();
  endtask

  // Concurrent assertion failures stop the run at the next edge
  always @(posedge clk)
  begin
    if (dut0.asrt0.fail_count != 0)
      stop_on_error("A concurrent assertion in spi_reg_assertions failed");
  end

  initial
  begin
    int cnt;
    seed_out   = $urandom(SEED);
    spi_clk    = CPOL;
    spi_cs_n   = 1'b1;
    spi_mosi   = 1'b0;
    model_regs = '{default: 8'h00};
    model_regs[0] = REG_ID_VALUE;

    cnt = 0;
    while (rst && (cnt < WAIT_LIMIT))
    begin
      @(posedge clk);
      cnt++;
    end
    if (rst)
      stop_on_error("Timed out waiting for reset to end");
    idle_cycles(2);

    // Command-only read after reset
    read_regs(4'($urandom_range(0, 15)), 0);
    check_ctrl(8'h00);

    // Single write and read back, then the control register
    addr = 4'($urandom_range(1, 15));
    write_regs(addr, 1, 8'($urandom_range(1, 255)));
    read_regs(addr, 1);
    data = 8'($urandom_range(1, 255));
    write_regs(4'd1, 1, data);
    check_ctrl(data);
    read_regs(4'd1, 1);

    // ID register ignores writes
    write_regs(4'd0, 1, 8'($urandom_range(0, 255)));
    read_regs(4'd0, 1);
    check_ctrl(model_regs[1]);

    // Random bursts, plus two that surely wrap
    repeat (16)
    begin
      addr = 4'($urandom_range(0, 15));
      if ($urandom_range(0, 1) == 1)
        write_regs(addr, int'($urandom_range(2, 6)), 8'($urandom_range(0, 255)));
      else
        read_regs(addr, int'($urandom_range(2, 6)));
    end
    write_regs(4'd13, 6, 8'($urandom_range(0, 255)));
    read_regs(4'd14, 6);
    check_ctrl(model_regs[1]);

    // Aborts inside the command byte and inside a write data byte
    abort_mid_byte(1'b0, 8'h00, 3);
    addr = 4'($urandom_range(1, 15));
    abort_mid_byte(1'b1, make_cmd(1'b1, addr), 5);
    read_regs(addr, 1);
    addr = 4'($urandom_range(0, 15));
    write_regs(addr, 3, 8'($urandom_range(0, 255)));
    read_regs(addr, 3);
    check_ctrl(model_regs[1]);

    idle_cycles(GAP_CYCLES);
    if (dut0.asrt0.fail_count != 0)
      stop_on_error("Concurrent assertions reported errors");
    else
    begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

// ==== tb/spi_reg_assertions.sv ====
////////////////////////////////////////////////////////////////////////////
// Protocol and register checks bound into spi_reg_top
// All properties are disabled while reset is high
// fail_count counts failed properties for the testbench to read
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spi_reg_assertions
  (
  input logic                   i_Clk,
  input logic                   i_rst,
  input logic                   i_spi_cs_n,
  input logic                   i_spi_miso_en,
  input spi_reg_pkg::spi_byte_t i_rx,
  input spi_reg_pkg::reg_req_t  i_req,
  input logic [7:0]             i_rd_data,
  input logic                   i_rd_valid,
  input logic [7:0]             i_ctrl
  );

  import spi_reg_pkg::*;

  int unsigned fail_count = 0;

  // MISO driver is on only while CS is low, one cycle of lag allowed
  miso_en_follows_cs: assert property (@(posedge i_Clk) disable iff (i_rst)
    (i_spi_miso_en == !i_spi_cs_n) || (i_spi_miso_en == !$past(i_spi_cs_n)))
  else
  begin
    $error("MISO enable does not follow chip select");
    fail_count++;
  end

  // Received-byte strobe is a single cycle
  rx_valid_single: assert property (@(posedge i_Clk) disable iff (i_rst)
    i_rx.valid |=> !i_rx.valid)
  else
  begin
    $error("Received-byte valid held for two cycles");
    fail_count++;
  end

  // Register 0 always answers with the ID constant
  id_read_constant: assert property (@(posedge i_Clk) disable iff (i_rst)
    (i_req.rd_en && (i_req.addr == '0)) |=> (i_rd_valid && (i_rd_data == REG_ID_VALUE)))
  else
  begin
    $error("Register 0 did not read the ID value");
    fail_count++;
  end

  // A write to address 0 touches no storage, so o_ctrl holds
  id_write_dropped: assert property (@(posedge i_Clk) disable iff (i_rst)
    (i_req.wr_en && (i_req.addr == '0)) |=> (i_ctrl == $past(i_ctrl)))
  else
  begin
    $error("Write to register 0 changed the bank");
    fail_count++;
  end

  // Control output is always defined out of reset
  ctrl_known: assert property (@(posedge i_Clk) disable iff (i_rst)
    !$isunknown(i_ctrl))
  else
  begin
    $error("o_ctrl is unknown");
    fail_count++;
  end

endmodule

// ==== tb/tb_clk_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset source
// 40 ns clock, reset held high for the first 8 rising edges
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clk_gen
  (
  output logic o_clk,
  output logic o_rst
  );

  // Free-running system clock
  initial
  begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk;
  end

  // Reset drops 1 ns after the eighth rising edge
  initial
  begin
    o_rst = 1'b1;
    repeat (8) @(posedge o_clk);
    #1;
    o_rst = 1'b0;
  end

endmodule

// ==== source/spi_reg_top.sv ====
////////////////////////////////////////////////////////////////////////////
// SPI-accessed register bank, top level
// SPI mode comes from the package default
// o_ctrl mirrors register 1
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spi_reg_top
  (
  input  logic       i_Clk,
  input  logic       i_rst,
  input  logic       i_spi_clk,
  input  logic       i_spi_cs_n,
  input  logic       i_spi_mosi,
  output logic       o_spi_miso,
  output logic       o_spi_miso_en,
  output logic [7:0] o_ctrl
  );

  import spi_reg_pkg::*;

  spi_byte_t  w_rx;
  spi_byte_t  w_tx;
  logic       w_cs_active;
  reg_req_t   w_req;
  logic [7:0] w_rd_data;
  logic       w_rd_valid;

  // Serial link and clock crossing
  spi_slave #(.SPI_MODE(SPI_MODE)) slave0
  (
    .i_Clk         (i_Clk),
    .i_rst         (i_rst),
    .i_spi_clk     (i_spi_clk),
    .i_spi_cs_n    (i_spi_cs_n),
    .i_spi_mosi    (i_spi_mosi),
    .i_tx          (w_tx),
    .o_rx          (w_rx),
    .o_cs_active   (w_cs_active),
    .o_spi_miso    (o_spi_miso),
    .o_spi_miso_en (o_spi_miso_en)
  );

  // Byte stream to register requests
  spi_cmd_decoder decoder0
  (
    .i_Clk       (i_Clk),
    .i_rst       (i_rst),
    .i_rx        (w_rx),
    .i_cs_active (w_cs_active),
    .i_rd_data   (w_rd_data),
    .i_rd_valid  (w_rd_valid),
    .o_req       (w_req),
    .o_tx        (w_tx)
  );

  reg_bank bank0
  (
    .i_Clk      (i_Clk),
    .i_rst      (i_rst),
    .i_req      (w_req),
    .o_rd_data  (w_rd_data),
    .o_rd_valid (w_rd_valid),
    .o_ctrl     (o_ctrl)
  );

endmodule

// ==== source/reg_bank.sv ====
////////////////////////////////////////////////////////////////////////////
// Sixteen 8-bit registers with a registered read port
// Register 0 is a read-only ID, writes to it are dropped
// Register 1 also drives the control output
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module reg_bank
  (
  input  logic                  i_Clk,
  input  logic                  i_rst,
  input  spi_reg_pkg::reg_req_t i_req,
  output logic [7:0]            o_rd_data,
  output logic                  o_rd_valid,
  output logic [7:0]            o_ctrl
  );

  import spi_reg_pkg::*;

  // Storage starts at 1 since address 0 is a constant
  logic [7:0] r_regs [1:REG_COUNT-1];
  logic [7:0] r_rd_data;
  logic       r_rd_valid;

  // Write port
  always_ff @(posedge i_Clk)
  begin
    if (i_rst)
    begin
      for (int i = 1; i < REG_COUNT; i++)
        r_regs[i] <= 8'h00;
    end
    else if (i_req.wr_en && (i_req.addr != '0))
    begin
      r_regs[i_req.addr] <= i_req.data;
    end
  end

  // Read strobe, one cycle behind the request
  always_ff @(posedge i_Clk)
  begin
    if (i_rst)
      r_rd_valid <= 1'b0;
    else
      r_rd_valid <= i_req.rd_en;
  end

  // Read data
  always_ff @(posedge i_Clk)
  begin
    if (i_req.rd_en)
      r_rd_data <= (i_req.addr == '0) ? REG_ID_VALUE : r_regs[i_req.addr];
  end

  assign o_rd_data  = r_rd_data;
  assign o_rd_valid = r_rd_valid;
  assign o_ctrl     = r_regs[1];

endmodule

// ==== source/spi_cmd_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// Command decoder for the SPI register bank
// First byte in a transaction is the command, later bytes are data
// Read data is prefetched one byte ahead of the master
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spi_cmd_decoder
  (
  input  logic                   i_Clk,
  input  logic                   i_rst,
  input  spi_reg_pkg::spi_byte_t i_rx,
  input  logic                   i_cs_active,
  input  logic [7:0]             i_rd_data,
  input  logic                   i_rd_valid,
  output spi_reg_pkg::reg_req_t  o_req,
  output spi_reg_pkg::spi_byte_t o_tx
  );

  import spi_reg_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COMMAND,
    ST_WRITE,
    ST_READ
  } state_t;

  state_t                r_state;
  logic                  r_cs_active_q;
  logic                  r_status_ld;
  logic [REG_ADDR_W-1:0] r_addr;
  logic                  r_wr_en;
  logic                  r_rd_en;
  logic [REG_ADDR_W-1:0] r_req_addr;
  logic [7:0]            r_req_data;
  logic [REG_ADDR_W-1:0] w_cmd_addr;

  // Start address from the low bits of the command byte
  assign w_cmd_addr = i_rx.data[REG_ADDR_W-1:0];

  // FSM, request strobes and running address
  always_ff @(posedge i_Clk)
  begin
    if (i_rst)
    begin
      r_state       <= ST_IDLE;
      r_cs_active_q <= 1'b0;
      r_status_ld   <= 1'b0;
      r_addr        <= '0;
      r_wr_en       <= 1'b0;
      r_rd_en       <= 1'b0;
    end
    else
    begin
      r_cs_active_q <= i_cs_active;
      // Status byte goes out during the command byte
      r_status_ld   <= i_cs_active & ~r_cs_active_q;
      r_wr_en       <= 1'b0;
      r_rd_en       <= 1'b0;

      if (!i_cs_active)
        r_state <= ST_IDLE;
      else
      begin
        case (r_state)
          ST_IDLE:
            r_state <= ST_COMMAND;
          ST_COMMAND:
            if (i_rx.valid)
            begin
              if (i_rx.data[CMD_WRITE_BIT])
              begin
                r_addr  <= w_cmd_addr;
                r_state <= ST_WRITE;
              end
              else
              begin
                // First read goes out now so data is ready for byte one
                r_rd_en <= 1'b1;
                r_addr  <= w_cmd_addr + REG_ADDR_W'(1);
                r_state <= ST_READ;
              end
            end
          ST_WRITE:
            if (i_rx.valid)
            begin
              r_wr_en <= 1'b1;
              r_addr  <= r_addr + REG_ADDR_W'(1);
            end
          ST_READ:
            if (i_rx.valid)
            begin
              r_rd_en <= 1'b1;
              r_addr  <= r_addr + REG_ADDR_W'(1);
            end
          default:
            r_state <= ST_IDLE;
        endcase
      end
    end
  end

  // Request address and data ride along with the strobes
  always_ff @(posedge i_Clk)
  begin
    if (i_rx.valid)
    begin
      r_req_addr <= (r_state == ST_COMMAND) ? w_cmd_addr : r_addr;
      r_req_data <= i_rx.data;
    end
  end

  assign o_req = '{wr_en: r_wr_en, rd_en: r_rd_en, addr: r_req_addr, data: r_req_data};

  // Status and read data never arrive in the same cycle
  assign o_tx = '{valid: r_status_ld | i_rd_valid,
                  data:  r_status_ld ? STATUS_VALUE : i_rd_data};

endmodule

// ==== source/spi_slave.sv ====
////////////////////////////////////////////////////////////////////////////
// SPI slave with byte receive and transmit, MSB first
// i_Clk must run at least 4x the SPI clock
// Master must idle SPI clock 8+ i_Clk cycles between bytes and after CS low
// CS high clears the SPI-domain bit counters
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spi_slave
  #(parameter int SPI_MODE = spi_reg_pkg::SPI_MODE)
  (
  input  logic                  i_Clk,
  input  logic                  i_rst,
  input  logic                  i_spi_clk,
  input  logic                  i_spi_cs_n,
  input  logic                  i_spi_mosi,
  input  spi_reg_pkg::spi_byte_t i_tx,
  output spi_reg_pkg::spi_byte_t o_rx,
  output logic                  o_cs_active,
  output logic                  o_spi_miso,
  output logic                  o_spi_miso_en
  );

  // Polarity and phase from the mode number
  localparam logic CPOL = (SPI_MODE == 2) || (SPI_MODE == 3);
  localparam logic CPHA = (SPI_MODE == 1) || (SPI_MODE == 3);

  logic       w_spi_clk;
  logic [2:0] r_rx_cnt;
  logic [6:0] r_rx_shift;
  logic [7:0] r_rx_byte;
  logic       r_rx_done;
  logic [2:0] r_tx_cnt;
  logic [2:0] w_tx_idx;
  logic [7:0] r_tx_byte;
  logic [2:0] r_done_sync;
  logic [1:0] r_cs_sync;
  logic       w_done_rise;
  logic       r_rx_valid;
  logic [7:0] r_rx_data;

  // Sampling edge is the rising edge of w_spi_clk
  // Rising SPI clock samples when polarity and phase agree
  assign w_spi_clk = (CPOL ^ CPHA) ? ~i_spi_clk : i_spi_clk;

  ////////////////////////////////////////////////////////////////////////////
  // SPI clock domain
  ////////////////////////////////////////////////////////////////////////////

  // Bit counter and done flag, both cleared while CS is high
  // Done stays up until the third bit of the next byte
  always_ff @(posedge w_spi_clk or posedge i_spi_cs_n)
  begin
    if (i_spi_cs_n)
    begin
      r_rx_cnt  <= 3'd0;
      r_rx_done <= 1'b0;
    end
    else
    begin
      r_rx_cnt <= r_rx_cnt + 3'd1;
      if (r_rx_cnt == 3'd7)
        r_rx_done <= 1'b1;
      else if (r_rx_cnt == 3'd2)
        r_rx_done <= 1'b0;
    end
  end

  // Shift MOSI in at the LSB
  // Full byte is captured on the eighth sample
  always_ff @(posedge w_spi_clk)
  begin
    r_rx_shift <= {r_rx_shift[5:0], i_spi_mosi};
    if (r_rx_cnt == 3'd7)
      r_rx_byte <= {r_rx_shift, i_spi_mosi};
  end

  // Transmit counter steps on the shift edge
  always_ff @(negedge w_spi_clk or posedge i_spi_cs_n)
  begin
    if (i_spi_cs_n)
      r_tx_cnt <= 3'd0;
    else
      r_tx_cnt <= r_tx_cnt + 3'd1;
  end

  // With phase 0 bit 7 sits on MISO before the first edge
  // With phase 1 the first shift edge presents bit 7
  assign w_tx_idx   = ~r_tx_cnt + {2'b00, CPHA};
  assign o_spi_miso = r_tx_byte[w_tx_idx];

  // Pin is released while CS is high so other slaves can drive it
  assign o_spi_miso_en = ~i_spi_cs_n;

  ////////////////////////////////////////////////////////////////////////////
  // System clock domain
  ////////////////////////////////////////////////////////////////////////////

  // Two synchronizer stages plus one for edge detect
  always_ff @(posedge i_Clk)
  begin
    if (i_rst)
    begin
      r_done_sync <= 3'b000;
      r_cs_sync   <= 2'b11;
      r_rx_valid  <= 1'b0;
    end
    else
    begin
      r_done_sync <= {r_done_sync[1:0], r_rx_done};
      r_cs_sync   <= {r_cs_sync[0], i_spi_cs_n};
      r_rx_valid  <= w_done_rise;
    end
  end

  assign w_done_rise = r_done_sync[1] & ~r_done_sync[2];

  // Received byte is quiet in the SPI domain here
  // so it can be sampled directly
  always_ff @(posedge i_Clk)
  begin
    if (w_done_rise)
      r_rx_data <= r_rx_byte;
  end

  // Transmit byte is loaded between bytes while SPI clock idles
  always_ff @(posedge i_Clk)
  begin
    if (i_tx.valid)
      r_tx_byte <= i_tx.data;
  end

  assign o_rx        = '{valid: r_rx_valid, data: r_rx_data};
  assign o_cs_active = ~r_cs_sync[1];

endmodule

// ==== source/spi_reg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types and constants for the SPI register bank
// Register 0 is read-only and returns REG_ID_VALUE
// Addresses wrap from REG_COUNT-1 back to 0 inside a burst
////////////////////////////////////////////////////////////////////////////

package spi_reg_pkg;

  // Default SPI mode for the slave and the testbench master
  localparam int SPI_MODE = 0;

  // Register bank geometry
  localparam int REG_COUNT  = 16;
  localparam int REG_ADDR_W = 4;

  // Fixed identification value in register 0
  localparam logic [7:0] REG_ID_VALUE = 8'hA5;

  // Byte shifted out on MISO while the command byte comes in
  localparam logic [7:0] STATUS_VALUE = 8'h5C;

  // Write flag position in the command byte, 1 selects write
  localparam int CMD_WRITE_BIT = 7;

  // One byte moving between the slave and the decoder
  // Valid is a single i_Clk pulse
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } spi_byte_t;

  // Register access from the decoder to the bank
  // Enables are single-cycle pulses
  typedef struct packed {
    logic                  wr_en;
    logic                  rd_en;
    logic [REG_ADDR_W-1:0] addr;
    logic [7:0]            data;
  } reg_req_t;

endpackage
